// File: files.f
+incdir+include
src/conv_pkg.sv
src/tap_sequencer.sv
src/tap_fifo.sv
src/weight_rom.sv
src/mac_lanes.sv
src/expand_conv_top.sv
test/expand_conv_sva.sv
test/tb_expand_conv.sv

// File: include/conv_cfg.svh
////////////////////////////////////////////////////////////
// Expand convolution sizing
// Lane count, window shape, requantization and FIFO depth
////////////////////////////////////////////////////////////
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// Output channels computed in parallel
`define CONV_LANES 4

// Taps per window, 3x3 kernel over 2 input channels
`define CONV_TAPS 18

// Output positions per run
`define CONV_WINDOWS 6

// Fraction bits dropped when requantizing to 16 bits
`define CONV_FRAC 6

// Default tap FIFO depth
`define CONV_FIFO_DEPTH 8

`endif

// File: run_sim.sh
#!/bin/sh
# Build and run the expand convolution testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_expand_conv -f files.f -o tb_expand_conv

./obj_dir/tb_expand_conv

// File: src/conv_pkg.sv
////////////////////////////////////////////////////////////
// Expand convolution shared types
// Data types, FIFO payload and coefficient rules
////////////////////////////////////////////////////////////
`default_nettype none
`include "conv_cfg.svh"

package conv_pkg;

	typedef logic signed [15:0] pixel_t;
	typedef logic signed [7:0] weight_t;
	typedef logic signed [31:0] acc_t;

	// One tagged pixel on its way to the lanes
	typedef struct packed {
		pixel_t pix;
		logic [4:0] tap;
		logic last_tap;
		logic last_win;
		logic layer;
	} tap_entry_t;

	// Per-lane vectors, lane 0 in the low bits
	typedef pixel_t [`CONV_LANES-1:0] pixel_vec_t;
	typedef weight_t [`CONV_LANES-1:0] weight_vec_t;
	typedef acc_t [`CONV_LANES-1:0] acc_vec_t;

	// Weight in -8..7 for a layer, lane and tap
	function automatic weight_t coef_weight(input int layer, input int lane, input int tap);
		int raw;
		raw = (tap * 3 + lane * 5 + layer * 7) % 16;
		return weight_t'(raw - 8);
	endfunction

	// Bias already scaled to the accumulator fraction
	function automatic acc_t coef_bias(input int layer, input int lane);
		return acc_t'((lane * 40 + layer * 25 - 60) * (1 << `CONV_FRAC));
	endfunction

endpackage

`default_nettype wire

// File: src/expand_conv_top.sv
////////////////////////////////////////////////////////////
// Expand convolution engine
// Sequencer, tap FIFO, weight ROM and MAC lanes
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "conv_cfg.svh"

module expand_conv_top (
	input logic clk,
	input logic rst,
	input logic start,
	input logic layer_sel,
	input conv_pkg::pixel_t pix_data,
	input logic pix_valid,
	output logic pix_ready,
	output conv_pkg::pixel_vec_t ofm_data,
	output logic ofm_valid,
	input logic ofm_ready,
	output logic busy,
	output logic done
);
	// Sequencer to FIFO
	conv_pkg::tap_entry_t seq_entry;
	logic seq_valid;
	logic seq_ready;

	// FIFO to lanes
	conv_pkg::tap_entry_t fifo_entry;
	logic fifo_valid;
	logic fifo_ready;

	// Lanes to ROM and back
	logic rom_layer;
	logic [4:0] rom_tap;
	conv_pkg::weight_vec_t lane_weight;
	conv_pkg::acc_vec_t lane_bias;

	tap_sequencer seq_i (
		.clk(clk),
		.rst(rst),
		.start(start),
		.layer_sel(layer_sel),
		.pix_data(pix_data),
		.pix_valid(pix_valid),
		.pix_ready(pix_ready),
		.seq_entry(seq_entry),
		.seq_valid(seq_valid),
		.seq_ready(seq_ready),
		.done(done),
		.busy(busy)
	);

	tap_fifo #(
		.DEPTH(`CONV_FIFO_DEPTH)
	) fifo_i (
		.clk(clk),
		.rst(rst),
		.in_entry(seq_entry),
		.in_valid(seq_valid),
		.in_ready(seq_ready),
		.out_entry(fifo_entry),
		.out_valid(fifo_valid),
		.out_ready(fifo_ready)
	);

	weight_rom rom_i (
		.clk(clk),
		.layer(rom_layer),
		.tap(rom_tap),
		.lane_weight(lane_weight),
		.lane_bias(lane_bias)
	);

	mac_lanes lanes_i (
		.clk(clk),
		.rst(rst),
		.fifo_entry(fifo_entry),
		.fifo_valid(fifo_valid),
		.fifo_ready(fifo_ready),
		.rom_layer(rom_layer),
		.rom_tap(rom_tap),
		.lane_weight(lane_weight),
		.lane_bias(lane_bias),
		.ofm_data(ofm_data),
		.ofm_valid(ofm_valid),
		.ofm_ready(ofm_ready),
		.done(done)
	);

endmodule

`default_nettype wire

// File: src/mac_lanes.sv
////////////////////////////////////////////////////////////
// MAC lane array
// Multiply-accumulate per lane, then bias, ReLU, requantize
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "conv_cfg.svh"

module mac_lanes (
	input logic clk,
	input logic rst,
	input conv_pkg::tap_entry_t fifo_entry,
	input logic fifo_valid,
	output logic fifo_ready,
	output logic rom_layer,
	output logic [4:0] rom_tap,
	input conv_pkg::weight_vec_t lane_weight,
	input conv_pkg::acc_vec_t lane_bias,
	output conv_pkg::pixel_vec_t ofm_data,
	output logic ofm_valid,
	input logic ofm_ready,
	output logic done
);
	localparam conv_pkg::acc_t SAT_MAX = 32767;

	logic stall;

	// Popped entry, ROM read in flight
	conv_pkg::tap_entry_t s1_entry;
	logic s1_valid;

	// Pixel with its coefficients
	conv_pkg::pixel_t s2_pix;
	conv_pkg::weight_vec_t s2_weight;
	conv_pkg::acc_vec_t s2_bias;
	logic s2_valid;
	logic s2_first;
	logic s2_last_tap;
	logic s2_last_win;

	// Accumulators and finished-window flag
	conv_pkg::acc_vec_t acc;
	conv_pkg::acc_vec_t s3_bias;
	logic s3_valid;
	logic s3_last_win;

	conv_pkg::acc_vec_t prod;
	conv_pkg::acc_vec_t biased;
	conv_pkg::pixel_vec_t result;
	logic ofm_last;

	// A held output freezes every stage
	assign stall = ofm_valid && !ofm_ready;
	assign fifo_ready = fifo_valid && !stall;

	// Address follows the entry that will sit in stage 1
	assign rom_layer = fifo_ready ? fifo_entry.layer : s1_entry.layer;
	assign rom_tap = fifo_ready ? fifo_entry.tap : s1_entry.tap;

	////////////////////////////////////////////////////////////
	// Lane arithmetic
	////////////////////////////////////////////////////////////
	always_comb begin
		conv_pkg::acc_t scaled;
		for (int l = 0; l < `CONV_LANES; l++) begin
			prod[l] = conv_pkg::acc_t'($signed(s2_pix)) * conv_pkg::acc_t'($signed(s2_weight[l]));
			biased[l] = acc[l] + s3_bias[l];
			scaled = $signed(biased[l]) >>> `CONV_FRAC;
			// ReLU, then clamp to the 16-bit range
			if (biased[l][31])
				result[l] = '0;
			else if (scaled > SAT_MAX)
				result[l] = 16'sd32767;
			else
				result[l] = scaled[15:0];
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			s3_valid <= 1'b0;
			ofm_valid <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= ofm_valid && ofm_ready && ofm_last;
			if (!stall) begin
				s1_valid <= fifo_ready;
				s2_valid <= s1_valid;
				s3_valid <= s2_valid && s2_last_tap;
				ofm_valid <= s3_valid;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fifo_ready)
			s1_entry <= fifo_entry;
		if (!stall) begin
			if (s1_valid) begin
				s2_pix <= s1_entry.pix;
				s2_weight <= lane_weight;
				s2_bias <= lane_bias;
				s2_first <= s1_entry.tap == 5'd0;
				s2_last_tap <= s1_entry.last_tap;
				s2_last_win <= s1_entry.last_win;
			end
			if (s2_valid) begin
				// Tap 0 starts a fresh window
				for (int l = 0; l < `CONV_LANES; l++)
					acc[l] <= s2_first ? prod[l] : acc[l] + prod[l];
				s3_bias <= s2_bias;
				s3_last_win <= s2_last_win;
			end
			if (s3_valid) begin
				ofm_data <= result;
				ofm_last <= s3_last_win;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/tap_fifo.sv
////////////////////////////////////////////////////////////
// Tap FIFO
// First-word fall-through buffer for tagged tap entries
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "conv_cfg.svh"

module tap_fifo #(
	parameter int DEPTH = `CONV_FIFO_DEPTH
) (
	input logic clk,
	input logic rst,
	input conv_pkg::tap_entry_t in_entry,
	input logic in_valid,
	output logic in_ready,
	output conv_pkg::tap_entry_t out_entry,
	output logic out_valid,
	input logic out_ready
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	conv_pkg::tap_entry_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	// Pointer step with wrap for any depth
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign in_ready = count != CNT_W'(DEPTH);
	assign out_valid = count != '0;
	assign out_entry = mem[rd_ptr];
	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_entry;
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			// Simultaneous push and pop leaves the count alone
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: src/tap_sequencer.sv
////////////////////////////////////////////////////////////
// Tap sequencer
// Tags incoming pixels with tap, window and layer per run
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "conv_cfg.svh"

module tap_sequencer (
	input logic clk,
	input logic rst,
	input logic start,
	input logic layer_sel,
	input conv_pkg::pixel_t pix_data,
	input logic pix_valid,
	output logic pix_ready,
	output conv_pkg::tap_entry_t seq_entry,
	output logic seq_valid,
	input logic seq_ready,
	input logic done,
	output logic busy
);
	localparam int WIN_W = $clog2(`CONV_WINDOWS);

	logic busy_q;
	logic feeding;
	logic layer_q;
	logic [4:0] tap_cnt;
	logic [WIN_W-1:0] win_cnt;
	logic last_tap;
	logic last_win;
	logic launch;
	logic take;

	// Start only counts while idle
	assign launch = start && !busy;
	// Busy drops together with the done pulse
	assign busy = busy_q && !done;

	assign last_tap = tap_cnt == 5'(`CONV_TAPS - 1);
	assign last_win = win_cnt == WIN_W'(`CONV_WINDOWS - 1);

	// Pixels pass straight through to the FIFO
	assign pix_ready = feeding && seq_ready;
	assign seq_valid = feeding && pix_valid;
	assign take = pix_valid && pix_ready;

	always_comb begin
		seq_entry.pix = pix_data;
		seq_entry.tap = tap_cnt;
		seq_entry.last_tap = last_tap;
		seq_entry.last_win = last_win;
		seq_entry.layer = layer_q;
	end

	////////////////////////////////////////////////////////////
	// Run state and counters
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			busy_q <= 1'b0;
			feeding <= 1'b0;
			layer_q <= 1'b0;
			tap_cnt <= '0;
			win_cnt <= '0;
		end else if (launch) begin
			busy_q <= 1'b1;
			feeding <= 1'b1;
			layer_q <= layer_sel;
			tap_cnt <= '0;
			win_cnt <= '0;
		end else begin
			if (done)
				busy_q <= 1'b0;
			if (take) begin
				if (last_tap) begin
					tap_cnt <= '0;
					win_cnt <= win_cnt + 1'b1;
					// Whole run handed over
					if (last_win)
						feeding <= 1'b0;
				end else begin
					tap_cnt <= tap_cnt + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: src/weight_rom.sv
////////////////////////////////////////////////////////////
// Weight ROM
// Registered lookup of all lane weights and biases
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "conv_cfg.svh"

module weight_rom (
	input logic clk,
	input logic layer,
	input logic [4:0] tap,
	output conv_pkg::weight_vec_t lane_weight,
	output conv_pkg::acc_vec_t lane_bias
);
	conv_pkg::weight_vec_t w_tab [2][`CONV_TAPS];
	conv_pkg::acc_vec_t b_tab [2];

	////////////////////////////////////////////////////////////
	// Constant tables, one set per layer
	////////////////////////////////////////////////////////////
	for (genvar g = 0; g < 2; g++) begin : g_layer
		for (genvar l = 0; l < `CONV_LANES; l++) begin : g_lane
			assign b_tab[g][l] = conv_pkg::coef_bias(g, l);
			for (genvar t = 0; t < `CONV_TAPS; t++) begin : g_tap
				assign w_tab[g][t][l] = conv_pkg::coef_weight(g, l, t);
			end
		end
	end

	// Read port, one cycle of latency
	always_ff @(posedge clk) begin
		if (tap < 5'(`CONV_TAPS))
			lane_weight <= w_tab[layer][tap];
		else
			lane_weight <= '0;
		lane_bias <= b_tab[layer];
	end

endmodule

`default_nettype wire

// File: test/expand_conv_sva.sv
////////////////////////////////////////////////////////////
// Expand convolution assertions
// Reset state, output hold and run status checks
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module expand_conv_sva (
	input logic clk,
	input logic rst,
	input logic busy,
	input logic done,
	input logic pix_ready,
	input logic ofm_valid,
	input logic ofm_ready,
	input conv_pkg::pixel_vec_t ofm_data
);
	// Everything quiet while reset is held
	reset_quiet: assert property (@(posedge clk)
		!rst |-> (!busy && !done && !pix_ready && !ofm_valid))
		else $error("status or handshake outputs high during reset");

	// A refused output keeps its word
	output_held: assert property (@(posedge clk) disable iff (!rst)
		$past(ofm_valid && !ofm_ready) |-> (ofm_valid && $stable(ofm_data)))
		else $error("ofm_data or ofm_valid changed while the output was stalled");

	done_in_run: assert property (@(posedge clk) disable iff (!rst)
		done |-> $past(busy))
		else $error("done pulsed while no run was active");

	idle_no_pixels: assert property (@(posedge clk) disable iff (!rst)
		!busy |-> !pix_ready)
		else $error("pixel stream ready while idle");

endmodule

bind expand_conv_top expand_conv_sva sva_i (
	.clk(clk),
	.rst(rst),
	.busy(busy),
	.done(done),
	.pix_ready(pix_ready),
	.ofm_valid(ofm_valid),
	.ofm_ready(ofm_ready),
	.ofm_data(ofm_data)
);

`default_nettype wire

// File: test/tb_expand_conv.sv
////////////////////////////////////////////////////////////
// Expand convolution testbench
// Three runs against a lane model with random output stalls
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "conv_cfg.svh"

module tb_expand_conv;
	localparam int RUN_PIX = `CONV_TAPS * `CONV_WINDOWS;
	// Three runs of 108 pixels take a few hundred cycles even with stalls
	localparam int MAX_CYCLES = 4000;
	localparam conv_pkg::pixel_t PIX_MAX = 16'sh7fff;
	localparam conv_pkg::pixel_t PIX_MIN = 16'sh8000;

	logic clk;
	logic rst;
	logic start;
	logic layer_sel;
	conv_pkg::pixel_t pix_data;
	logic pix_valid;
	logic pix_ready;
	conv_pkg::pixel_vec_t ofm_data;
	logic ofm_valid;
	logic ofm_ready;
	logic busy;
	logic done;

	conv_pkg::pixel_t pixels [RUN_PIX];
	conv_pkg::pixel_vec_t expected [$];
	logic [31:0] pix_state;
	logic [31:0] ready_state;
	logic stall_mode;
	int run_outputs;
	int done_count;
	int cycles;

	expand_conv_top dut_i (
		.clk(clk),
		.rst(rst),
		.start(start),
		.layer_sel(layer_sel),
		.pix_data(pix_data),
		.pix_valid(pix_valid),
		.pix_ready(pix_ready),
		.ofm_data(ofm_data),
		.ofm_valid(ofm_valid),
		.ofm_ready(ofm_ready),
		.busy(busy),
		.done(done)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	////////////////////////////////////////////////////////////
	// Reference model of the lane arithmetic
	////////////////////////////////////////////////////////////
	function automatic int kernel_weight(input int layer, input int lane, input int tap);
		return ((tap * 3 + lane * 5 + layer * 7) % 16) - 8;
	endfunction

	function automatic int lane_offset(input int layer, input int lane);
		return (lane * 40 + layer * 25 - 60) * (1 << `CONV_FRAC);
	endfunction

	// ReLU, drop fraction bits, clamp at the top of the 16-bit range
	function automatic conv_pkg::pixel_t requantize(input int sum);
		if (sum < 0)
			return '0;
		if ((sum >>> `CONV_FRAC) > 32767)
			return PIX_MAX;
		return conv_pkg::pixel_t'(sum >>> `CONV_FRAC);
	endfunction

	task automatic build_expected(input int layer);
		conv_pkg::pixel_vec_t want;
		int sum;
		for (int w = 0; w < `CONV_WINDOWS; w++) begin
			for (int l = 0; l < `CONV_LANES; l++) begin
				sum = lane_offset(layer, l);
				for (int t = 0; t < `CONV_TAPS; t++)
					sum += int'(pixels[w * `CONV_TAPS + t]) * kernel_weight(layer, l, t);
				want[l] = requantize(sum);
			end
			expected.push_back(want);
		end
	endtask

	task automatic fill_random();
		for (int i = 0; i < RUN_PIX; i++) begin
			pix_state = lcg_step(pix_state);
			pixels[i] = conv_pkg::pixel_t'(pix_state[23:8]);
		end
	endtask

	// Windows 0-1 follow the lane 0 weight signs, 2-3 oppose them, 4-5 alternate
	task automatic fill_chosen();
		int wt;
		for (int w = 0; w < `CONV_WINDOWS; w++) begin
			for (int t = 0; t < `CONV_TAPS; t++) begin
				wt = kernel_weight(0, 0, t);
				if (w < 2)
					pixels[w * `CONV_TAPS + t] = (wt >= 0) ? PIX_MAX : PIX_MIN;
				else if (w < 4)
					pixels[w * `CONV_TAPS + t] = (wt >= 0) ? PIX_MIN : PIX_MAX;
				else
					pixels[w * `CONV_TAPS + t] = (t % 2 == 0) ? PIX_MAX : PIX_MIN;
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////
	task automatic send_pixel(input conv_pkg::pixel_t p);
		logic taken;
		pix_data = p;
		pix_valid = 1'b1;
		do begin
			@(negedge clk);
			taken = pix_ready;
			@(posedge clk);
			#1;
		end while (!taken);
	endtask

	task automatic do_run(input logic layer, input logic stalls, input logic poke_start);
		int target;
		target = done_count + 1;
		stall_mode = stalls;
		start = 1'b1;
		layer_sel = layer;
		@(posedge clk);
		#1;
		start = 1'b0;
		for (int i = 0; i < RUN_PIX; i++) begin
			// A second start mid-run must be ignored
			if (poke_start && i == 40) begin
				start = 1'b1;
				layer_sel = !layer;
			end
			send_pixel(pixels[i]);
			start = 1'b0;
		end
		pix_valid = 1'b0;
		while (done_count < target) begin
			@(posedge clk);
			#1;
		end
		stall_mode = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Output ready, random while stalls are on
	initial begin
		forever begin
			@(posedge clk);
			#1;
			ready_state = lcg_step(ready_state);
			ofm_ready = rst && (!stall_mode || ready_state[20]);
		end
	end

	initial begin
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles >= MAX_CYCLES)
				abort_run("Timeout: the runs did not finish within the cycle limit");
		end
	end

	////////////////////////////////////////////////////////////
	// Output and done checks
	////////////////////////////////////////////////////////////
	always @(negedge clk) begin
		conv_pkg::pixel_vec_t want;
		if (rst && ofm_valid && ofm_ready) begin
			assert (expected.size() != 0)
				else abort_run("An output was accepted with no expected word left");
			want = expected.pop_front();
			assert (ofm_data == want)
				else abort_run($sformatf("Mismatch ofm_data: got %h expected %h",
					ofm_data, want));
			run_outputs++;
		end
		if (rst && done) begin
			assert (run_outputs == `CONV_WINDOWS)
				else abort_run("done pulsed before all six outputs of the run were accepted");
			assert (!busy)
				else abort_run("busy was still high during the done pulse");
			run_outputs = 0;
			done_count++;
		end
	end

	initial begin
		rst = 1'b0;
		start = 1'b0;
		layer_sel = 1'b0;
		pix_data = '0;
		pix_valid = 1'b0;
		ofm_ready = 1'b0;
		stall_mode = 1'b0;
		pix_state = 32'd23;
		ready_state = 32'd23;
		run_outputs = 0;
		done_count = 0;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b1;
		@(posedge clk);
		#1;

		// Layer 0, no stalls, ignored restart
		fill_random();
		build_expected(0);
		do_run(1'b0, 1'b0, 1'b1);

		// Layer 1 under random stalls
		fill_random();
		build_expected(1);
		do_run(1'b1, 1'b1, 1'b0);

		// Saturation and ReLU corners
		fill_chosen();
		build_expected(0);
		do_run(1'b0, 1'b1, 1'b0);

		repeat (4) @(posedge clk);
		assert (expected.size() == 0)
			else abort_run("Expected outputs were left over after the last run");
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire
